// File: hdl/ant_defs.svh
`ifndef ANT_DEFS_SVH
`define ANT_DEFS_SVH

// Coordinate and datapath widths
`define X_COORD_WIDTH 8
`define Y_COORD_WIDTH 7
`define DATA_WIDTH 8
`define MEM_ADDR_WIDTH 8
`define ID_WIDTH 6

// Screen and ant block size in pixels
`define SCREEN_WIDTH 160
`define SCREEN_HEIGHT 120
`define ANT_WIDTH 3
`define ANT_HEIGHT 3

// Ant record layout, four bytes per ant
`define ANT_REC_SIZE 4
`define ANT_X_OFS 0
`define ANT_Y_OFS 1
`define ANT_ADDR(id, ofs) `MEM_ADDR_WIDTH'((id) * `ANT_REC_SIZE + (ofs))

// Datapath opcodes
`define OPCODE_WIDTH 2
`define OP_MEMREAD `OPCODE_WIDTH'd1
`define OP_MEMWRITE `OPCODE_WIDTH'd2
`define OP_DRAW `OPCODE_WIDTH'd3

// Pixel colour
`define COLOUR_WIDTH 3
`define ANT_COLOUR 3'b100

`endif

// File: hdl/ant_pkg.sv
`default_nettype none

`include "ant_defs.svh"

package ant_pkg;

    typedef struct packed {
        logic [`COLOUR_WIDTH-1:0] colour;
        logic [`Y_COORD_WIDTH-1:0] y;
        logic [`X_COORD_WIDTH-1:0] x;
    } pixel_t;

    // Data is the write value, pixel is the draw target
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        pixel_t pixel;
    } dp_instr_t;

    typedef struct packed {
        logic valid;
        dp_instr_t instr;
    } dp_req_t;

    typedef struct packed {
        logic valid;
        logic [`DATA_WIDTH-1:0] result;
    } dp_rsp_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

    typedef struct packed {
        logic valid;
        logic [`ID_WIDTH-1:0] id;
    } draw_cmd_t;

    typedef struct packed {
        logic valid;
        logic [`ID_WIDTH-1:0] id;
        move_t move;
    } update_cmd_t;

endpackage

`default_nettype wire

// File: hdl/dp_link.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_defs.svh"

module dp_link (
    input  wire clock,
    input  wire resetn,
    input  wire ant_pkg::dp_req_t draw_req,
    input  wire ant_pkg::dp_req_t update_req,
    output ant_pkg::dp_rsp_t draw_rsp,
    output ant_pkg::dp_rsp_t update_rsp,
    output logic dp_start,
    output ant_pkg::dp_instr_t dp_instr,
    input  wire dp_finished,
    input  wire [`DATA_WIDTH-1:0] dp_result
);
    import ant_pkg::*;

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_START,
        LINK_DELAY,
        LINK_WAIT
    } link_state_t;

    link_state_t state;
    logic draw_pend;
    logic update_pend;
    dp_instr_t draw_pend_instr;
    dp_instr_t update_pend_instr;
    logic serve_update;
    logic draw_rsp_valid;
    logic update_rsp_valid;
    logic [`DATA_WIDTH-1:0] result_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= LINK_IDLE;
            draw_pend <= 1'b0;
            update_pend <= 1'b0;
            serve_update <= 1'b0;
            dp_start <= 1'b0;
            draw_rsp_valid <= 1'b0;
            update_rsp_valid <= 1'b0;
        end else begin
            draw_rsp_valid <= 1'b0;
            update_rsp_valid <= 1'b0;
            case (state)
                // Update port wins a tie
                LINK_IDLE: begin
                    if (update_pend) begin
                        update_pend <= 1'b0;
                        serve_update <= 1'b1;
                        dp_start <= 1'b1;
                        state <= LINK_START;
                    end else if (draw_pend) begin
                        draw_pend <= 1'b0;
                        serve_update <= 1'b0;
                        dp_start <= 1'b1;
                        state <= LINK_START;
                    end
                end
                LINK_START: begin
                    state <= LINK_DELAY;
                end
                LINK_DELAY: begin
                    dp_start <= 1'b0;
                    state <= LINK_WAIT;
                end
                LINK_WAIT: begin
                    if (dp_finished) begin
                        draw_rsp_valid <= !serve_update;
                        update_rsp_valid <= serve_update;
                        state <= LINK_IDLE;
                    end
                end
                default: state <= LINK_IDLE;
            endcase
            // A fresh strobe is latched until served
            if (draw_req.valid) begin
                draw_pend <= 1'b1;
            end
            if (update_req.valid) begin
                update_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (draw_req.valid) begin
            draw_pend_instr <= draw_req.instr;
        end
        if (update_req.valid) begin
            update_pend_instr <= update_req.instr;
        end
        // Held stable from selection until the datapath finishes
        if (state == LINK_IDLE) begin
            if (update_pend) begin
                dp_instr <= update_pend_instr;
            end else if (draw_pend) begin
                dp_instr <= draw_pend_instr;
            end
        end
        if (state == LINK_WAIT && dp_finished) begin
            result_q <= dp_result;
        end
    end

    assign draw_rsp = '{valid: draw_rsp_valid, result: result_q};
    assign update_rsp = '{valid: update_rsp_valid, result: result_q};

endmodule

`default_nettype wire

// File: hdl/ant_draw_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_defs.svh"

module ant_draw_seq (
    input  wire clock,
    input  wire resetn,
    input  wire ant_pkg::draw_cmd_t cmd,
    output logic busy,
    output logic done,
    output ant_pkg::dp_req_t req,
    input  wire ant_pkg::dp_rsp_t rsp
);
    import ant_pkg::*;

    localparam int DX_WIDTH = $clog2(`ANT_WIDTH);
    localparam int DY_WIDTH = $clog2(`ANT_HEIGHT);

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_READ_X,
        DRAW_READ_Y,
        DRAW_PIXEL
    } draw_state_t;

    draw_state_t state;
    logic req_valid;
    logic [DX_WIDTH-1:0] dx;
    logic [DY_WIDTH-1:0] dy;
    logic [`ID_WIDTH-1:0] id;
    logic [`X_COORD_WIDTH-1:0] corner_x;
    logic [`Y_COORD_WIDTH-1:0] corner_y;
    dp_instr_t instr;

    // Instruction for the step in progress, sampled by the link with req.valid
    always_comb begin
        instr = '0;
        case (state)
            DRAW_READ_Y: begin
                instr.opcode = `OP_MEMREAD;
                instr.addr = `ANT_ADDR(id, `ANT_Y_OFS);
            end
            DRAW_PIXEL: begin
                instr.opcode = `OP_DRAW;
                instr.pixel.colour = `ANT_COLOUR;
                instr.pixel.x = corner_x + `X_COORD_WIDTH'(dx);
                instr.pixel.y = corner_y + `Y_COORD_WIDTH'(dy);
            end
            default: begin
                instr.opcode = `OP_MEMREAD;
                instr.addr = `ANT_ADDR(id, `ANT_X_OFS);
            end
        endcase
    end

    assign req = '{valid: req_valid, instr: instr};

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= DRAW_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            req_valid <= 1'b0;
            dx <= '0;
            dy <= '0;
        end else begin
            done <= 1'b0;
            req_valid <= 1'b0;
            case (state)
                DRAW_IDLE: begin
                    if (cmd.valid) begin
                        busy <= 1'b1;
                        req_valid <= 1'b1;
                        state <= DRAW_READ_X;
                    end
                end
                DRAW_READ_X: begin
                    if (rsp.valid) begin
                        req_valid <= 1'b1;
                        state <= DRAW_READ_Y;
                    end
                end
                DRAW_READ_Y: begin
                    if (rsp.valid) begin
                        dx <= '0;
                        dy <= '0;
                        req_valid <= 1'b1;
                        state <= DRAW_PIXEL;
                    end
                end
                // Raster order, dx runs fastest
                DRAW_PIXEL: begin
                    if (rsp.valid) begin
                        if (dx == DX_WIDTH'(`ANT_WIDTH - 1)) begin
                            dx <= '0;
                            if (dy == DY_WIDTH'(`ANT_HEIGHT - 1)) begin
                                busy <= 1'b0;
                                done <= 1'b1;
                                state <= DRAW_IDLE;
                            end else begin
                                dy <= dy + 1'b1;
                                req_valid <= 1'b1;
                            end
                        end else begin
                            dx <= dx + 1'b1;
                            req_valid <= 1'b1;
                        end
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    // Block corner is one less than the stored centre
    always_ff @(posedge clock) begin
        if (state == DRAW_IDLE && cmd.valid) begin
            id <= cmd.id;
        end
        if (state == DRAW_READ_X && rsp.valid) begin
            corner_x <= rsp.result[`X_COORD_WIDTH-1:0] - 1'b1;
        end
        if (state == DRAW_READ_Y && rsp.valid) begin
            corner_y <= rsp.result[`Y_COORD_WIDTH-1:0] - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ant_update_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_defs.svh"

module ant_update_seq (
    input  wire clock,
    input  wire resetn,
    input  wire ant_pkg::update_cmd_t cmd,
    output logic busy,
    output logic done,
    output ant_pkg::dp_req_t req,
    input  wire ant_pkg::dp_rsp_t rsp
);
    import ant_pkg::*;

    typedef enum logic [2:0] {
        UPD_IDLE,
        UPD_READ_X,
        UPD_READ_Y,
        UPD_MOVE,
        UPD_WRITE_X,
        UPD_WRITE_Y
    } upd_state_t;

    upd_state_t state;
    logic req_valid;
    logic [`ID_WIDTH-1:0] id;
    move_t move;
    logic [`X_COORD_WIDTH-1:0] x;
    logic [`Y_COORD_WIDTH-1:0] y;
    logic [`X_COORD_WIDTH-1:0] next_x;
    logic [`Y_COORD_WIDTH-1:0] next_y;
    dp_instr_t instr;

    // Keep the whole ant block on screen
    always_comb begin
        next_x = x;
        next_y = y;
        if (move.left && next_x > (`ANT_WIDTH / 2)) begin
            next_x = next_x - 1'b1;
        end
        if (move.right && next_x < (`SCREEN_WIDTH - (`ANT_WIDTH / 2) - 1)) begin
            next_x = next_x + 1'b1;
        end
        if (move.up && next_y > (`ANT_HEIGHT / 2)) begin
            next_y = next_y - 1'b1;
        end
        if (move.down && next_y < (`SCREEN_HEIGHT - (`ANT_HEIGHT / 2) - 1)) begin
            next_y = next_y + 1'b1;
        end
    end

    always_comb begin
        instr = '0;
        case (state)
            UPD_READ_Y: begin
                instr.opcode = `OP_MEMREAD;
                instr.addr = `ANT_ADDR(id, `ANT_Y_OFS);
            end
            UPD_WRITE_X: begin
                instr.opcode = `OP_MEMWRITE;
                instr.addr = `ANT_ADDR(id, `ANT_X_OFS);
                instr.data = `DATA_WIDTH'(x);
            end
            UPD_WRITE_Y: begin
                instr.opcode = `OP_MEMWRITE;
                instr.addr = `ANT_ADDR(id, `ANT_Y_OFS);
                instr.data = `DATA_WIDTH'(y);
            end
            default: begin
                instr.opcode = `OP_MEMREAD;
                instr.addr = `ANT_ADDR(id, `ANT_X_OFS);
            end
        endcase
    end

    assign req = '{valid: req_valid, instr: instr};

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= UPD_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            done <= 1'b0;
            req_valid <= 1'b0;
            case (state)
                UPD_IDLE: begin
                    if (cmd.valid) begin
                        busy <= 1'b1;
                        req_valid <= 1'b1;
                        state <= UPD_READ_X;
                    end
                end
                UPD_READ_X: begin
                    if (rsp.valid) begin
                        req_valid <= 1'b1;
                        state <= UPD_READ_Y;
                    end
                end
                UPD_READ_Y: begin
                    if (rsp.valid) begin
                        state <= UPD_MOVE;
                    end
                end
                UPD_MOVE: begin
                    req_valid <= 1'b1;
                    state <= UPD_WRITE_X;
                end
                UPD_WRITE_X: begin
                    if (rsp.valid) begin
                        req_valid <= 1'b1;
                        state <= UPD_WRITE_Y;
                    end
                end
                UPD_WRITE_Y: begin
                    if (rsp.valid) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                        state <= UPD_IDLE;
                    end
                end
                default: state <= UPD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == UPD_IDLE && cmd.valid) begin
            id <= cmd.id;
            move <= cmd.move;
        end
        if (state == UPD_READ_X && rsp.valid) begin
            x <= rsp.result[`X_COORD_WIDTH-1:0];
        end
        if (state == UPD_READ_Y && rsp.valid) begin
            y <= rsp.result[`Y_COORD_WIDTH-1:0];
        end
        // Moved position, written back in the next two steps
        if (state == UPD_MOVE) begin
            x <= next_x;
            y <= next_y;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ant_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_defs.svh"

module ant_engine (
    input  wire clock,
    input  wire resetn,
    input  wire ant_pkg::draw_cmd_t draw_cmd,
    input  wire ant_pkg::update_cmd_t update_cmd,
    output logic draw_busy,
    output logic draw_done,
    output logic update_busy,
    output logic update_done,
    output logic dp_start,
    output ant_pkg::dp_instr_t dp_instr,
    input  wire dp_finished,
    input  wire [`DATA_WIDTH-1:0] dp_result
);

    // Sequencer side of the shared datapath link
    wire ant_pkg::dp_req_t draw_req;
    wire ant_pkg::dp_req_t update_req;
    wire ant_pkg::dp_rsp_t draw_rsp;
    wire ant_pkg::dp_rsp_t update_rsp;

    ant_draw_seq draw_seq_i (
        .clock(clock),
        .resetn(resetn),
        .cmd(draw_cmd),
        .busy(draw_busy),
        .done(draw_done),
        .req(draw_req),
        .rsp(draw_rsp)
    );

    ant_update_seq update_seq_i (
        .clock(clock),
        .resetn(resetn),
        .cmd(update_cmd),
        .busy(update_busy),
        .done(update_done),
        .req(update_req),
        .rsp(update_rsp)
    );

    dp_link dp_link_i (
        .clock(clock),
        .resetn(resetn),
        .draw_req(draw_req),
        .update_req(update_req),
        .draw_rsp(draw_rsp),
        .update_rsp(update_rsp),
        .dp_start(dp_start),
        .dp_instr(dp_instr),
        .dp_finished(dp_finished),
        .dp_result(dp_result)
    );

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter real PERIOD = 40.0,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2.0) clock = ~clock;
    end

    // Reset lets go a little after the edge, like every other input
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/ant_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_defs.svh"

module ant_engine_tb;
    import ant_pkg::*;

    // Worst case for one instruction, counting a wait behind the other port
    localparam int INSTR_CYCLES = 20;
    localparam int DRAW_CYCLES = (2 + `ANT_WIDTH * `ANT_HEIGHT) * INSTR_CYCLES;
    localparam int UPDATE_CYCLES = 5 * INSTR_CYCLES;
    localparam int TEST_CYCLES = 3 * DRAW_CYCLES + 5 * UPDATE_CYCLES + 100;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic clock;
    logic resetn;
    draw_cmd_t draw_cmd;
    update_cmd_t update_cmd;
    logic draw_busy;
    logic draw_done;
    logic update_busy;
    logic update_done;
    logic dp_start;
    dp_instr_t dp_instr;
    logic dp_finished;
    logic [`DATA_WIDTH-1:0] dp_result;

    logic [`DATA_WIDTH-1:0] mem [0:(1 << `MEM_ADDR_WIDTH)-1];
    pixel_t draw_log[$];
    logic [7:0] lfsr_state;
    logic instr_live;
    int draw_done_count;
    int update_done_count;
    int value_errors;
    int protocol_errors;
    int cycle_count;

    clock_gen #(.PERIOD(40.0), .RESET_CYCLES(2)) clock_gen_i (
        .clock(clock),
        .resetn(resetn)
    );

    ant_engine ant_engine_i (
        .clock(clock),
        .resetn(resetn),
        .draw_cmd(draw_cmd),
        .update_cmd(update_cmd),
        .draw_busy(draw_busy),
        .draw_done(draw_done),
        .update_busy(update_busy),
        .update_done(update_done),
        .dp_start(dp_start),
        .dp_instr(dp_instr),
        .dp_finished(dp_finished),
        .dp_result(dp_result)
    );

    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic int ant_addr(input int id, input int ofs);
        return id * `ANT_REC_SIZE + ofs;
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("** Error %s: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("Protocol error at %0t: %s", $time, what);
    endtask

    // Datapath model, answers 1 to 4 cycles after dp_start falls
    initial begin : datapath_model
        logic start_seen;
        int wait_cycles;
        dp_instr_t instr;
        dp_finished = 1'b0;
        dp_result = '0;
        lfsr_state = 8'd58;
        start_seen = 1'b0;
        for (int i = 0; i < (1 << `MEM_ADDR_WIDTH); i++) begin
            mem[i] = `DATA_WIDTH'(i) ^ 8'hA5;
        end
        forever begin
            @(posedge clock);
            #1;
            if (start_seen && !dp_start) begin
                instr = dp_instr;
                take_random(2, wait_cycles);
                repeat (wait_cycles + 1) @(posedge clock);
                #2;
                dp_result = '0;
                case (instr.opcode)
                    `OP_MEMREAD: dp_result = mem[instr.addr];
                    `OP_MEMWRITE: mem[instr.addr] = instr.data;
                    `OP_DRAW: draw_log.push_back(instr.pixel);
                    default: dp_result = '0;
                endcase
                dp_finished = 1'b1;
                @(posedge clock);
                #2;
                dp_finished = 1'b0;
                start_seen = 1'b0;
            end else begin
                start_seen = dp_start;
            end
        end
    end

    always @(posedge clock) begin
        if (draw_done === 1'b1) begin
            draw_done_count <= draw_done_count + 1;
        end
        if (update_done === 1'b1) begin
            update_done_count <= update_done_count + 1;
        end
        if (!resetn) begin
            instr_live <= 1'b0;
        end else if (dp_start) begin
            instr_live <= 1'b1;
        end else if (dp_finished) begin
            instr_live <= 1'b0;
        end
    end

    assert property (@(posedge clock) !resetn |=> !dp_start && !draw_busy && !update_busy
            && !draw_done && !update_done)
        else protocol_error("outputs not idle after reset");
    assert property (@(posedge clock) disable iff (!resetn) $rose(dp_start) |=> dp_start)
        else protocol_error("dp_start high for only one cycle");
    assert property (@(posedge clock) disable iff (!resetn)
            dp_start && $past(dp_start) |=> !dp_start)
        else protocol_error("dp_start high for more than two cycles");
    assert property (@(posedge clock) disable iff (!resetn)
            dp_start || (instr_live && !dp_finished) |=> $stable(dp_instr))
        else protocol_error("dp_instr changed before dp_finished");
    assert property (@(posedge clock) disable iff (!resetn)
            !draw_busy && draw_cmd.valid |=> draw_busy)
        else protocol_error("draw_busy did not rise after a draw command");
    assert property (@(posedge clock) disable iff (!resetn)
            !update_busy && update_cmd.valid |=> update_busy)
        else protocol_error("update_busy did not rise after an update command");
    assert property (@(posedge clock) disable iff (!resetn)
            $fell(draw_busy) |-> draw_done)
        else protocol_error("draw_busy fell without draw_done");
    assert property (@(posedge clock) disable iff (!resetn)
            $fell(update_busy) |-> update_done)
        else protocol_error("update_busy fell without update_done");
    assert property (@(posedge clock) disable iff (!resetn) draw_done |=> !draw_done)
        else protocol_error("draw_done longer than one cycle");
    assert property (@(posedge clock) disable iff (!resetn) update_done |=> !update_done)
        else protocol_error("update_done longer than one cycle");

    task automatic set_ant(input int id, input int x, input int y);
        mem[ant_addr(id, `ANT_X_OFS)] = `DATA_WIDTH'(x);
        mem[ant_addr(id, `ANT_Y_OFS)] = `DATA_WIDTH'(y);
    endtask

    task automatic issue(input logic draw_v, input int draw_id, input logic update_v,
            input int update_id, input move_t mv);
        @(posedge clock);
        #2;
        draw_cmd = '{valid: draw_v, id: `ID_WIDTH'(draw_id)};
        update_cmd = '{valid: update_v, id: `ID_WIDTH'(update_id), move: mv};
        @(posedge clock);
        #2;
        draw_cmd.valid = 1'b0;
        update_cmd.valid = 1'b0;
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(posedge clock);
        #1;
    endtask

    // Blocks until both done counters reach their targets
    task automatic wait_done(input int draw_target, input int update_target);
        while (draw_done_count < draw_target || update_done_count < update_target) begin
            @(posedge clock);
            #1;
        end
    endtask

    // Raster order from the corner one less than the stored position
    task automatic check_draw(input string test, input int x, input int y);
        int dx;
        int dy;
        check_value({test, " pixel count"}, `ANT_WIDTH * `ANT_HEIGHT, draw_log.size());
        for (int idx = 0; idx < draw_log.size(); idx++) begin
            dx = idx % `ANT_WIDTH;
            dy = idx / `ANT_WIDTH;
            check_value($sformatf("%s pixel %0d x", test, idx), x - 1 + dx, draw_log[idx].x);
            check_value($sformatf("%s pixel %0d y", test, idx), y - 1 + dy, draw_log[idx].y);
            check_value($sformatf("%s pixel %0d colour", test, idx), `ANT_COLOUR,
                draw_log[idx].colour);
        end
    endtask

    task automatic check_ant(input string test, input int id, input int x, input int y);
        check_value({test, " x"}, x, mem[ant_addr(id, `ANT_X_OFS)]);
        check_value({test, " y"}, y, mem[ant_addr(id, `ANT_Y_OFS)]);
    endtask

    task automatic run_update(input string test, input int id, input int x, input int y,
            input move_t mv, input int exp_x, input int exp_y);
        int update_base;
        set_ant(id, x, y);
        update_base = update_done_count;
        issue(1'b0, 0, 1'b1, id, mv);
        wait_done(draw_done_count, update_base + 1);
        check_ant(test, id, exp_x, exp_y);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: jobs still running after %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        move_t no_move;
        move_t right_down;
        move_t left_up;
        int draw_base;
        int update_base;
        draw_cmd = '0;
        update_cmd = '0;
        no_move = '0;
        right_down = '{left: 1'b0, right: 1'b1, up: 1'b0, down: 1'b1};
        left_up = '{left: 1'b1, right: 1'b0, up: 1'b1, down: 1'b0};
        wait (resetn === 1'b1);
        settle(1);

        check_value("reset dp_start", 0, dp_start);
        check_value("reset draw_busy", 0, draw_busy);
        check_value("reset update_busy", 0, update_busy);
        check_value("reset draw_done", 0, draw_done);
        check_value("reset update_done", 0, update_done);

        set_ant(2, 50, 40);
        draw_log.delete();
        draw_base = draw_done_count;
        issue(1'b1, 2, 1'b0, 0, no_move);
        wait_done(draw_base + 1, update_done_count);
        settle(4);
        check_draw("draw_ant", 50, 40);
        check_value("draw_ant done count", 1, draw_done_count - draw_base);

        run_update("update_move", 3, 50, 40, right_down, 51, 41);
        run_update("update_low_edge", 4, 1, 1, left_up, 1, 1);
        run_update("update_high_edge", 5, 158, 118, right_down, 158, 118);

        // Both sequencers share the link
        set_ant(6, 20, 30);
        set_ant(7, 100, 60);
        draw_log.delete();
        draw_base = draw_done_count;
        update_base = update_done_count;
        issue(1'b1, 6, 1'b1, 7, left_up);
        wait_done(draw_base + 1, update_base + 1);
        check_draw("draw_with_update", 20, 30);
        check_ant("draw_with_update moved", 7, 99, 59);
        check_ant("draw_with_update drawn", 6, 20, 30);

        // Second commands land while both jobs are busy
        set_ant(8, 70, 70);
        set_ant(9, 10, 10);
        set_ant(10, 30, 20);
        draw_log.delete();
        draw_base = draw_done_count;
        update_base = update_done_count;
        issue(1'b1, 8, 1'b1, 10, right_down);
        settle(3);
        issue(1'b1, 9, 1'b1, 10, right_down);
        wait_done(draw_base + 1, update_base + 1);
        settle(40);
        check_value("busy_ignore draw done count", 1, draw_done_count - draw_base);
        check_value("busy_ignore update done count", 1, update_done_count - update_base);
        check_value("busy_ignore draw_busy", 0, draw_busy);
        check_value("busy_ignore update_busy", 0, update_busy);
        check_draw("busy_ignore", 70, 70);
        check_ant("busy_ignore", 10, 31, 21);

        $display("Checks done: %0d value errors, %0d protocol errors",
            value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/ant_pkg.sv
hdl/dp_link.sv
hdl/ant_draw_seq.sv
hdl/ant_update_seq.sv
hdl/ant_engine.sv
bench/clock_gen.sv
bench/ant_engine_tb.sv

// File: Bender.yml
package:
  name: ant_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ant_pkg.sv
      - hdl/dp_link.sv
      - hdl/ant_draw_seq.sv
      - hdl/ant_update_seq.sv
      - hdl/ant_engine.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/clock_gen.sv
      - bench/ant_engine_tb.sv
